// File: Bender.yml
package:
  name: mem_stage

sources:
  - common/mem_pkg.sv
  - mem_access/mem_byte_sequencer.sv
  - mem_access/mem_result_stage.sv
  - source/mem_stage.sv
  - target: test
    files:
      - test/tb_mem_stage.sv

// File: common/mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared constants and bundles for the memory-access stage. Modules pull
// them in with a wildcard import in their module header.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int BYTE_W     = 8;
    localparam int HALF_W     = 2 * BYTE_W;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int REG_ADDR_W = 5;

    // Byte lane index within a word, and beat counter (up to 4 bytes + 2 idle)
    localparam int LANE_W = 2;
    localparam int BEAT_W = 3;

    ////////////////////////////////////////////////////////////////////////
    // Opcodes and funct3 decoding
    ////////////////////////////////////////////////////////////////////////

    localparam logic [OPCODE_W-1:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPCODE_STORE = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPCODE_NOP   = 7'b0000000;

    // Low funct3 bits give the access size
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'b00;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'b01;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'b10;

    // Set for LBU / LHU
    localparam int FUNCT3_UNSIGNED = 2;

    ////////////////////////////////////////////////////////////////////////
    // Memory controller commands
    ////////////////////////////////////////////////////////////////////////

    localparam logic [1:0] BUS_IDLE  = 2'b00;
    localparam logic [1:0] BUS_READ  = 2'b01;
    localparam logic [1:0] BUS_WRITE = 2'b10;

    ////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [FUNCT3_W-1:0]   funct3;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } mem_wb_t;

    typedef struct packed {
        logic [1:0]        cmd;
        logic [XLEN-1:0]   addr;
        logic [BYTE_W-1:0] wdata;
    } memctrl_req_t;

    localparam mem_wb_t MEM_WB_BUBBLE = '{
        opcode: OPCODE_NOP, we: 1'b0, waddr: '0, wdata: '0
    };

    localparam memctrl_req_t MEMCTRL_IDLE = '{cmd: BUS_IDLE, addr: '0, wdata: '0};

endpackage

`default_nettype wire

// File: mem_access/mem_byte_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Issue side of the memory stage: walks a load or store one byte per cycle
// over the byte-wide memory controller and holds the pipeline meanwhile.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_byte_sequencer import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    // Instruction from the EX/MEM register
    input  ex_mem_t           ex_mem_i,

    // Byte request to the memory controller
    output memctrl_req_t      memctrl_o,

    output logic              stall_o,
    output logic              capture_o,
    output logic [LANE_W-1:0] capture_lane_o,
    output logic              done_o
);

    logic              is_load;
    logic              is_store;
    logic              mem_op;
    logic [BEAT_W-1:0] num_bytes;
    logic [BEAT_W-1:0] last_beat;
    logic              issue;
    memctrl_req_t      req_d;

    logic [BEAT_W-1:0] beat_q;
    logic              done_q;
    logic              capture_q;
    logic [LANE_W-1:0] lane_q;
    memctrl_req_t      req_q;

    ////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////

    assign is_load  = (ex_mem_i.opcode == OPCODE_LOAD);
    assign is_store = (ex_mem_i.opcode == OPCODE_STORE);
    assign mem_op   = is_load | is_store;

    always_comb begin
        case (ex_mem_i.funct3[SIZE_W-1:0])
            SIZE_BYTE: num_bytes = BEAT_W'(1);
            SIZE_HALF: num_bytes = BEAT_W'(2);
            SIZE_WORD: num_bytes = BEAT_W'(4);
            default:   num_bytes = BEAT_W'(4);
        endcase
    end

    // Two idle beats follow the last byte before done
    assign last_beat = num_bytes + BEAT_W'(1);

    assign stall_o = mem_op & ~done_q;
    assign issue   = stall_o & (beat_q < num_bytes);

    ////////////////////////////////////////////////////////////////////////
    // Byte request
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        req_d = MEMCTRL_IDLE;
        if (issue) begin
            req_d.cmd  = is_store ? BUS_WRITE : BUS_READ;
            req_d.addr = ex_mem_i.alu_result + XLEN'(beat_q);
            if (is_store) begin
                // Little endian, byte k of rs2 goes to base+k
                req_d.wdata = ex_mem_i.store_data[BYTE_W*beat_q[LANE_W-1:0] +: BYTE_W];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Beat counter
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            beat_q    <= '0;
            done_q    <= 1'b0;
            capture_q <= 1'b0;
            lane_q    <= '0;
            req_q     <= MEMCTRL_IDLE;
        end else begin
            req_q     <= req_d;
            capture_q <= 1'b0;
            if (stall_o) begin
                if (beat_q == last_beat) begin
                    beat_q <= '0;
                    done_q <= 1'b1;
                end else begin
                    beat_q <= beat_q + BEAT_W'(1);
                    done_q <= 1'b0;
                end
                // Read byte of beat k returns two cycles after beat k
                if (is_load && (beat_q != '0) && (beat_q <= num_bytes)) begin
                    capture_q <= 1'b1;
                    lane_q    <= LANE_W'(beat_q - BEAT_W'(1));
                end
            end else begin
                beat_q <= '0;
                done_q <= 1'b0;
            end
        end
    end

    assign memctrl_o      = req_q;
    assign capture_o      = capture_q;
    assign capture_lane_o = lane_q;
    assign done_o         = done_q;

    ////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////

    a_cmd_legal: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        memctrl_o.cmd != 2'b11
    ) else $error("memory controller saw reserved command");

    // A request only ever follows a stalled cycle
    a_idle_without_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !stall_o |=> (memctrl_o.cmd == BUS_IDLE)
    ) else $error("memory request issued without a stall");

endmodule

`default_nettype wire

// File: mem_access/mem_result_stage.sv
////////////////////////////////////////////////////////////////////////////
// Collect and writeback side of the memory stage: gathers load bytes into a
// word, extends it and forms the MEM/WB bundle or a bubble.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_result_stage import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    input  ex_mem_t           ex_mem_i,
    input  logic [BYTE_W-1:0] memctrl_rdata_i,

    // From the byte sequencer
    input  logic              stall_i,
    input  logic              capture_i,
    input  logic [LANE_W-1:0] capture_lane_i,
    input  logic              done_i,

    output mem_wb_t           mem_wb_o
);

    logic            is_load;
    logic [XLEN-1:0] word_q;
    logic [XLEN-1:0] load_word;

    ////////////////////////////////////////////////////////////////////////
    // Load extension
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [XLEN-1:0] extend_load(
        input logic [XLEN-1:0]     raw,
        input logic [FUNCT3_W-1:0] funct3
    );
        logic fill;
        logic [XLEN-1:0] result;

        case (funct3[SIZE_W-1:0])
            SIZE_BYTE: begin
                fill   = ~funct3[FUNCT3_UNSIGNED] & raw[BYTE_W-1];
                result = {{(XLEN-BYTE_W){fill}}, raw[BYTE_W-1:0]};
            end
            SIZE_HALF: begin
                fill   = ~funct3[FUNCT3_UNSIGNED] & raw[HALF_W-1];
                result = {{(XLEN-HALF_W){fill}}, raw[HALF_W-1:0]};
            end
            default: begin
                result = raw;
            end
        endcase
        return result;
    endfunction

    assign is_load   = (ex_mem_i.opcode == OPCODE_LOAD);
    assign load_word = extend_load(word_q, ex_mem_i.funct3);

    ////////////////////////////////////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i || done_i) begin
            word_q <= '0;
        end else if (capture_i) begin
            word_q[BYTE_W*capture_lane_i +: BYTE_W] <= memctrl_rdata_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // MEM/WB bundle
    ////////////////////////////////////////////////////////////////////////

    // Bubble while in reset or stalled
    always_comb begin
        mem_wb_o = MEM_WB_BUBBLE;
        if (rst_n_i && !stall_i) begin
            mem_wb_o.opcode = ex_mem_i.opcode;
            mem_wb_o.we     = ex_mem_i.we;
            mem_wb_o.waddr  = ex_mem_i.waddr;
            if (done_i) begin
                // Stores write nothing back
                mem_wb_o.wdata = is_load ? load_word : '0;
            end else begin
                mem_wb_o.wdata = ex_mem_i.alu_result;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////

    // Done must end the stall in the very cycle it is seen
    a_done_ends_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(done_i && stall_i)
    ) else $error("done and stall high together");

endmodule

`default_nettype wire

// File: source/mem_stage.sv
////////////////////////////////////////////////////////////////////////////
// Memory-access stage top: byte sequencer plus result stage, placed between
// the EX/MEM register, the byte-wide memory controller and writeback.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_stage import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    // From EX/MEM, held by upstream while stalled
    input  ex_mem_t           ex_mem_i,

    // Memory controller
    input  logic [BYTE_W-1:0] memctrl_rdata_i,
    output memctrl_req_t      memctrl_o,

    // Writeback and stall control
    output mem_wb_t           mem_wb_o,
    output logic              stall_o
);

    logic              stall;
    logic              capture;
    logic [LANE_W-1:0] capture_lane;
    logic              done;

    mem_byte_sequencer u_sequencer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ex_mem_i       (ex_mem_i),
        .memctrl_o      (memctrl_o),
        .stall_o        (stall),
        .capture_o      (capture),
        .capture_lane_o (capture_lane),
        .done_o         (done)
    );

    mem_result_stage u_result (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_mem_i        (ex_mem_i),
        .memctrl_rdata_i (memctrl_rdata_i),
        .stall_i         (stall),
        .capture_i       (capture),
        .capture_lane_i  (capture_lane),
        .done_i          (done),
        .mem_wb_o        (mem_wb_o)
    );

    assign stall_o = stall;

endmodule

`default_nettype wire

// File: sources.f
common/mem_pkg.sv
mem_access/mem_byte_sequencer.sv
mem_access/mem_result_stage.sv
source/mem_stage.sv
test/tb_mem_stage.sv

// File: test/tb_mem_stage.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the memory stage: byte-memory model of the controller,
// directed and random loads, stores and ALU ops, checked against a model.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage import mem_pkg::*; ();

    localparam int NUM_INSTR      = 40;
    localparam int NUM_DIRECTED   = 10;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 50;
    localparam logic [OPCODE_W-1:0] OPCODE_ALU = 7'b0110011;
    localparam mem_wb_t BUBBLE = '{opcode: OPCODE_NOP, we: 1'b0, waddr: '0, wdata: '0};

    logic              clk;
    logic              rst_n_i;
    ex_mem_t           ex_mem_i;
    logic [BYTE_W-1:0] rdata_q;
    memctrl_req_t      memctrl_o;
    mem_wb_t           mem_wb_o;
    logic              stall_o;

    logic [7:0] model_mem [0:255];
    logic [7:0] shadow_mem [0:255];
    integer     seed;
    int         errors;
    int         cycle_cnt;
    int         stall_cnt;
    int         exp_stall;
    int         n_bytes;
    logic       mem_op;
    mem_wb_t    exp_wb;
    ex_mem_t    ins;

    mem_stage UUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_mem_i        (ex_mem_i),
        .memctrl_rdata_i (rdata_q),
        .memctrl_o       (memctrl_o),
        .mem_wb_o        (mem_wb_o),
        .stall_o         (stall_o)
    );

    always #4 clk = ~clk;

    // Byte-wide controller, read data one cycle after the command
    always @(posedge clk) begin
        if (memctrl_o.cmd == BUS_WRITE) begin
            model_mem[memctrl_o.addr[7:0]] <= memctrl_o.wdata;
        end
        rdata_q <= (memctrl_o.cmd == BUS_READ) ? model_mem[memctrl_o.addr[7:0]] : 8'h00;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the stage never finished", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    function automatic int access_bytes(input logic [FUNCT3_W-1:0] funct3);
        case (funct3[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic mem_wb_t expected_wb(input ex_mem_t in);
        mem_wb_t     wb;
        logic [31:0] raw;
        int          n;
        int          k;
        wb.opcode = in.opcode;
        wb.we     = in.we;
        wb.waddr  = in.waddr;
        wb.wdata  = in.alu_result;
        n = access_bytes(in.funct3);
        if (in.opcode == OPCODE_STORE) begin
            wb.wdata = '0;
        end else if (in.opcode == OPCODE_LOAD) begin
            raw = '0;
            for (k = 0; k < n; k++) begin
                raw[8*k +: 8] = shadow_mem[8'(in.alu_result + k)];
            end
            // Sign fill unless funct3 bit 2 marks an unsigned load
            if (!in.funct3[2] && n == 1 && raw[7]) raw[31:8] = '1;
            if (!in.funct3[2] && n == 2 && raw[15]) raw[31:16] = '1;
            wb.wdata = raw;
        end
        return wb;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Compare process, sampled at the falling edge
    ////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n_i) begin
            n_bytes = access_bytes(ex_mem_i.funct3);
            mem_op  = (ex_mem_i.opcode == OPCODE_LOAD) || (ex_mem_i.opcode == OPCODE_STORE);
            if (stall_o) begin
                check_value("mem_wb_o", mem_wb_o, BUBBLE);
                if (stall_cnt >= 1 && stall_cnt <= n_bytes) begin
                    check_value("memctrl_o.cmd", memctrl_o.cmd,
                                (ex_mem_i.opcode == OPCODE_STORE) ? BUS_WRITE : BUS_READ);
                    check_value("memctrl_o.addr", memctrl_o.addr,
                                ex_mem_i.alu_result + stall_cnt - 1);
                    if (ex_mem_i.opcode == OPCODE_STORE) begin
                        check_value("memctrl_o.wdata", memctrl_o.wdata,
                                    ex_mem_i.store_data[8*(stall_cnt-1) +: 8]);
                    end
                end else begin
                    check_value("memctrl_o.cmd", memctrl_o.cmd, BUS_IDLE);
                end
                stall_cnt = stall_cnt + 1;
            end else begin
                check_value("memctrl_o.cmd", memctrl_o.cmd, BUS_IDLE);
                // Non-memory instructions must not stall at all
                exp_stall = mem_op ? n_bytes + 2 : 0;
                if (stall_cnt != exp_stall) begin
                    report_failure($sformatf("stall lasted %0d cycles instead of %0d",
                                             stall_cnt, exp_stall));
                end
                exp_wb = expected_wb(ex_mem_i);
                check_value("mem_wb_o.opcode", mem_wb_o.opcode, exp_wb.opcode);
                check_value("mem_wb_o.we", mem_wb_o.we, exp_wb.we);
                check_value("mem_wb_o.waddr", mem_wb_o.waddr, exp_wb.waddr);
                check_value("mem_wb_o.wdata", mem_wb_o.wdata, exp_wb.wdata);
                if (ex_mem_i.opcode == OPCODE_STORE) begin
                    for (int k = 0; k < n_bytes; k++) begin
                        check_value("model_mem", model_mem[8'(ex_mem_i.alu_result + k)],
                                    ex_mem_i.store_data[8*k +: 8]);
                        shadow_mem[8'(ex_mem_i.alu_result + k)] = ex_mem_i.store_data[8*k +: 8];
                    end
                end
                stall_cnt = 0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////

    function automatic ex_mem_t make_instr(input logic [OPCODE_W-1:0] opcode,
                                           input logic [2:0] funct3, input logic we,
                                           input logic [4:0] waddr, input logic [31:0] addr,
                                           input logic [31:0] data);
        ex_mem_t r;
        r = '{opcode: opcode, funct3: funct3, we: we, waddr: waddr,
              alu_result: addr, store_data: data};
        return r;
    endfunction

    task automatic make_random(output ex_mem_t r);
        int kind;
        int pick;
        kind         = ($random(seed) & 32'h7fff_ffff) % 3;
        pick         = ($random(seed) & 32'h7fff_ffff) % 5;
        r.we         = 1'($random(seed));
        r.waddr      = REG_ADDR_W'($random(seed));
        r.alu_result = $random(seed);
        r.store_data = $random(seed);
        case (kind)
            0: begin
                r.opcode     = OPCODE_LOAD;
                r.funct3     = (pick < 3) ? 3'(pick) : 3'(pick + 1);
                r.alu_result = r.alu_result & 32'hff;
            end
            1: begin
                r.opcode     = OPCODE_STORE;
                r.funct3     = 3'(pick % 3);
                r.alu_result = r.alu_result & 32'hff;
            end
            default: begin
                r.opcode = OPCODE_ALU;
                r.funct3 = 3'(pick);
            end
        endcase
    endtask

    // Hold the bundle until the stall drops
    task automatic run_instr(input ex_mem_t r);
        @(posedge clk);
        ex_mem_i <= r;
        @(negedge clk);
        while (stall_o) @(negedge clk);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        ex_mem_i  = make_instr(OPCODE_ALU, 3'b000, 1'b1, 5'd9, 32'hcafe_f00d, 32'h0);
        rdata_q   = '0;
        seed      = 24;
        errors    = 0;
        cycle_cnt = 0;
        stall_cnt = 0;
        // Top bit set in the low 64 bytes
        for (int i = 0; i < 256; i++) begin
            model_mem[i]  = 8'(i) ^ 8'hc3;
            shadow_mem[i] = 8'(i) ^ 8'hc3;
        end
        // Live ALU bundle in reset still gives a bubble
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("mem_wb_o", mem_wb_o, BUBBLE);
        @(posedge clk);
        rst_n_i  <= 1'b1;
        ex_mem_i <= '0;
        @(negedge clk);
        check_value("mem_wb_o", mem_wb_o, BUBBLE);
        check_value("stall_o", stall_o, 1'b0);
        check_value("memctrl_o", memctrl_o,
                    memctrl_req_t'{cmd: BUS_IDLE, addr: '0, wdata: '0});

        run_instr(make_instr(OPCODE_ALU, 3'b000, 1'b1, 5'd5, 32'h1234_5678, 32'hdead_beef));
        run_instr(make_instr(OPCODE_LOAD, 3'b000, 1'b1, 5'd1, 32'h10, 32'h0));
        run_instr(make_instr(OPCODE_LOAD, 3'b100, 1'b1, 5'd2, 32'h11, 32'h0));
        run_instr(make_instr(OPCODE_LOAD, 3'b001, 1'b1, 5'd3, 32'h12, 32'h0));
        run_instr(make_instr(OPCODE_LOAD, 3'b101, 1'b1, 5'd4, 32'h14, 32'h0));
        run_instr(make_instr(OPCODE_LOAD, 3'b010, 1'b1, 5'd6, 32'h18, 32'h0));
        run_instr(make_instr(OPCODE_STORE, 3'b000, 1'b0, 5'd0, 32'h40, 32'h1122_3344));
        run_instr(make_instr(OPCODE_STORE, 3'b001, 1'b1, 5'd7, 32'h50, 32'h5566_7788));
        run_instr(make_instr(OPCODE_STORE, 3'b010, 1'b0, 5'd0, 32'h60, 32'h99aa_bbcc));
        run_instr(make_instr(OPCODE_LOAD, 3'b010, 1'b1, 5'd8, 32'h60, 32'h0));

        for (int i = 0; i < NUM_INSTR - NUM_DIRECTED; i++) begin
            make_random(ins);
            run_instr(ins);
        end

        repeat (2) @(posedge clk);
        $display("Run finished after %0d cycles with %0d errors", cycle_cnt, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
